/* hdl/acc_pkg.sv */
// accelerator shared definitions
`default_nettype none

package acc_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 128;
  localparam int LANE_W      = 32;
  localparam int LANES       = DATA_W / LANE_W;
  localparam int BLOCK_WORDS = 4;
  localparam int LITE_ADDR_W = 12;
  localparam int LITE_DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [7:0]        axlen_t;

  localparam axlen_t ARLEN_BLOCK = axlen_t'(BLOCK_WORDS - 1);

  // control register map
  localparam logic [LITE_ADDR_W-1:0] REG_CTRL = 12'h000;
  localparam logic [LITE_ADDR_W-1:0] REG_IFM  = 12'h010;
  localparam logic [LITE_ADDR_W-1:0] REG_WGT  = 12'h018;
  localparam logic [LITE_ADDR_W-1:0] REG_OFM  = 12'h020;

  typedef struct packed {
    addr_t  araddr;
    axlen_t arlen;
  } axi_ar_t;

  typedef struct packed {
    word_t rdata;
    logic  rlast;
  } axi_r_t;

  typedef struct packed {
    addr_t  awaddr;
    axlen_t awlen;
  } axi_aw_t;

  typedef struct packed {
    word_t               wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                wlast;
  } axi_w_t;

  typedef struct packed {
    logic [LITE_ADDR_W-1:0] awaddr;
  } lite_aw_t;

  typedef struct packed {
    logic [LITE_DATA_W-1:0]   wdata;
    logic [LITE_DATA_W/8-1:0] wstrb;
  } lite_w_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    WRITE,
    DONE
  } seq_state_t;

endpackage

`default_nettype wire

/* hdl/acc_ctrl_regs.sv */
// AXI4-Lite control slave
`default_nettype none
`timescale 1ns/1ps

module acc_ctrl_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            s_awvalid,
  input  acc_pkg::lite_aw_t               s_aw,
  output logic                            s_awready,
  input  logic                            s_wvalid,
  input  acc_pkg::lite_w_t                s_w,
  output logic                            s_wready,
  output logic                            s_bvalid,
  output logic [1:0]                      s_bresp,
  input  logic                            s_bready,
  input  logic                            s_arvalid,
  input  logic [acc_pkg::LITE_ADDR_W-1:0] s_araddr,
  output logic                            s_arready,
  output logic                            s_rvalid,
  output logic [acc_pkg::LITE_DATA_W-1:0] s_rdata,
  output logic [1:0]                      s_rresp,
  input  logic                            s_rready,
  output logic                            ap_start,
  input  logic                            ap_done,
  input  logic                            ap_idle,
  output acc_pkg::addr_t                  ifm_base,
  output acc_pkg::addr_t                  wgt_base,
  output acc_pkg::addr_t                  ofm_base
);
  import acc_pkg::*;

  logic                   wr_en;
  logic                   rd_en;
  logic                   done_q;
  logic [LITE_DATA_W-1:0] rd_mux;

  function automatic addr_t merge_bytes(addr_t cur, lite_w_t w);
    addr_t res;
    res = cur;
    for (int b = 0; b < LITE_DATA_W / 8; b++) begin
      if (w.wstrb[b]) begin
        res[b*8 +: 8] = w.wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // address and data taken together with one write in flight
  assign wr_en     = s_awvalid && s_wvalid && !s_bvalid;
  assign s_awready = wr_en;
  assign s_wready  = wr_en;
  assign s_bresp   = 2'b00;

  assign s_arready = !s_rvalid;
  assign rd_en     = s_arvalid && s_arready;
  assign s_rresp   = 2'b00;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_bvalid <= 1'b0;
      ap_start <= 1'b0;
      ifm_base <= '0;
      wgt_base <= '0;
      ofm_base <= '0;
    end else begin
      ap_start <= 1'b0;
      if (wr_en) begin
        s_bvalid <= 1'b1;
      end else if (s_bready) begin
        s_bvalid <= 1'b0;
      end
      if (wr_en) begin
        case (s_aw.awaddr)
          // start only counts while the engine is idle
          REG_CTRL: ap_start <= s_w.wstrb[0] && s_w.wdata[0] && ap_idle;
          REG_IFM:  ifm_base <= merge_bytes(ifm_base, s_w);
          REG_WGT:  wgt_base <= merge_bytes(wgt_base, s_w);
          REG_OFM:  ofm_base <= merge_bytes(ofm_base, s_w);
          default:  ;
        endcase
      end
    end
  end

  always_comb begin
    case (s_araddr)
      REG_CTRL: rd_mux = {{(LITE_DATA_W-3){1'b0}}, ap_idle, done_q, 1'b0};
      REG_IFM:  rd_mux = ifm_base;
      REG_WGT:  rd_mux = wgt_base;
      REG_OFM:  rd_mux = ofm_base;
      default:  rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_rvalid <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      if (rd_en) begin
        s_rvalid <= 1'b1;
      end else if (s_rready) begin
        s_rvalid <= 1'b0;
      end
      // a new done wins over a clearing read
      done_q <= ap_done || (done_q && !(rd_en && s_araddr == REG_CTRL))
;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      s_rdata <= rd_mux;
    end
  end

  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) ap_start |-> ap_idle
  );

endmodule

`default_nettype wire

/* hdl/axi_burst_reader.sv */
// AXI4 block read master
`default_nettype none
`timescale 1ns/1ps

module axi_burst_reader (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             fetch_start,
  input  acc_pkg::addr_t   base,
  output acc_pkg::axi_ar_t ar,
  output logic             arvalid,
  input  logic             arready,
  input  acc_pkg::axi_r_t  r,
  input  logic             rvalid,
  output logic             rready,
  output logic             word_valid,
  output acc_pkg::word_t   word,
  input  logic             word_ready,
  output logic             fetch_done
);
  import acc_pkg::*;

  addr_t  addr_q;
  logic   busy;
  logic   beat_hs;
  axlen_t beat_cnt;

  assign ar = '{araddr: addr_q, arlen: ARLEN_BLOCK};

  // beats pass straight through, the consumer's ready stalls the bus
  assign word_valid = busy && rvalid;
  assign word       = r.rdata;
  assign rready     = busy && word_ready;
  assign beat_hs    = rvalid && rready;
  assign fetch_done = beat_hs && r.rlast;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arvalid  <= 1'b0;
      busy     <= 1'b0;
      beat_cnt <= '0;
    end else begin
      if (fetch_start) begin
        arvalid  <= 1'b1;
        busy     <= 1'b1;
        beat_cnt <= '0;
      end else begin
        if (arready) begin
          arvalid <= 1'b0;
        end
        if (fetch_done) begin
          busy <= 1'b0;
        end
        if (beat_hs) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_start) begin
      addr_q <= base;
    end
  end

  a_rlast_on_last_beat: assert property (
    @(posedge clk) disable iff (!rst_n)
    beat_hs |-> (r.rlast == (beat_cnt == ARLEN_BLOCK))
  );

endmodule

`default_nettype wire

/* hdl/axi_word_writer.sv */
// AXI4 single word write master
`default_nettype none
`timescale 1ns/1ps

module axi_word_writer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             write_start,
  input  acc_pkg::addr_t   base,
  input  acc_pkg::word_t   result,
  output acc_pkg::axi_aw_t aw,
  output logic             awvalid,
  input  logic             awready,
  output acc_pkg::axi_w_t  w,
  output logic             wvalid,
  input  logic             wready,
  input  logic             bvalid,
  output logic             bready,
  output logic             write_done
);
  import acc_pkg::*;

  addr_t addr_q;
  word_t data_q;
  logic  busy;

  assign aw = '{awaddr: addr_q, awlen: '0};
  assign w  = '{wdata: data_q, wstrb: '1, wlast: 1'b1};

  // response taken once address and data are both gone
  assign bready     = busy && !awvalid && !wvalid;
  assign write_done = bvalid && bready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      busy    <= 1'b0;
    end else begin
      if (write_start) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        busy    <= 1'b1;
      end else begin
        if (awready) begin
          awvalid <= 1'b0;
        end
        if (wready) begin
          wvalid <= 1'b0;
        end
        if (write_done) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_start) begin
      addr_q <= base;
      data_q <= result;
    end
  end

  a_w_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(w)
  );

endmodule

`default_nettype wire

/* hdl/acc_sequencer.sv */
// engine control FSM
`default_nettype none
`timescale 1ns/1ps

module acc_sequencer (
  input  logic clk,
  input  logic rst_n,
  input  logic ap_start,
  input  logic ifm_done,
  input  logic wgt_done,
  input  logic result_valid,
  input  logic write_done,
  output logic fetch_start,
  output logic write_start,
  output logic ap_done,
  output logic ap_idle
);
  import acc_pkg::*;

  seq_state_t state;
  logic       ifm_got;
  logic       wgt_got;
  logic       res_got;
  logic       all_in;

  // both blocks read and the sum ready by this cycle
  assign all_in = (ifm_got || ifm_done) && (wgt_got || wgt_done) &&
                  (res_got || result_valid);

  assign ap_idle = (state == IDLE);
  assign ap_done = (state == DONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= IDLE;
      fetch_start <= 1'b0;
      write_start <= 1'b0;
      ifm_got     <= 1'b0;
      wgt_got     <= 1'b0;
      res_got     <= 1'b0;
    end else begin
      fetch_start <= 1'b0;
      write_start <= 1'b0;
      case (state)
        IDLE: begin
          if (ap_start) begin
            state       <= FETCH;
            fetch_start <= 1'b1;
            ifm_got     <= 1'b0;
            wgt_got     <= 1'b0;
            res_got     <= 1'b0;
          end
        end
        FETCH: begin
          ifm_got <= ifm_got || ifm_done;
          wgt_got <= wgt_got || wgt_done;
          res_got <= res_got || result_valid;
          if (all_in) begin
            state       <= WRITE;
            write_start <= 1'b1;
          end
        end
        WRITE: begin
          if (write_done) begin
            state <= DONE;
          end
        end
        DONE:    state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  a_done_in_fetch: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ifm_done || wgt_done || result_valid) |-> state == FETCH
  );

endmodule

`default_nettype wire

/* hdl/mac_engine.sv */
// lane multiply-accumulate datapath
`default_nettype none
`timescale 1ns/1ps

module mac_engine (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           fetch_start,
  input  logic           ifm_valid,
  input  acc_pkg::word_t ifm_word,
  input  logic           wgt_valid,
  input  acc_pkg::word_t wgt_word,
  output logic           pair_ready,
  output logic           result_valid,
  output acc_pkg::word_t result
);
  import acc_pkg::*;

  word_t                            ifm_be;
  word_t                            wgt_be;
  lane_t                            acc [LANES];
  logic [$clog2(BLOCK_WORDS)-1:0]   pair_cnt;

  // memory holds little-endian words
  function automatic word_t rev_bytes(word_t d);
    word_t res;
    for (int b = 0; b < DATA_W / 8; b++) begin
      res[b*8 +: 8] = d[(DATA_W/8-1-b)*8 +: 8];
    end
    return res;
  endfunction

  function automatic lane_t swap_lane(lane_t d);
    lane_t res;
    for (int b = 0; b < LANE_W / 8; b++) begin
      res[b*8 +: 8] = d[(LANE_W/8-1-b)*8 +: 8];
    end
    return res;
  endfunction

  // a pair moves only when both words are there
  assign pair_ready = ifm_valid && wgt_valid;
  assign ifm_be     = rev_bytes(ifm_word);
  assign wgt_be     = rev_bytes(wgt_word);

  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      if (fetch_start) begin
        acc[l] <= '0;
      end else if (pair_ready) begin
        // product truncated to the lane width
        acc[l] <= acc[l] + ifm_be[l*LANE_W +: LANE_W] * wgt_be[l*LANE_W +: LANE_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pair_cnt     <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= pair_ready && (pair_cnt == BLOCK_WORDS - 1);
      if (fetch_start) begin
        pair_cnt <= '0;
      end else if (pair_ready) begin
        pair_cnt <= pair_cnt + 1'b1;
      end
    end
  end

  for (genvar l = 0; l < LANES; l++) begin : g_out_lane
    assign result[l*LANE_W +: LANE_W] = swap_lane(acc[l]);
  end

endmodule

`default_nettype wire

/* hdl/krnl_acc.sv */
// accelerator kernel top
`default_nettype none
`timescale 1ns/1ps

module krnl_acc (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            s_awvalid,
  input  acc_pkg::lite_aw_t               s_aw,
  output logic                            s_awready,
  input  logic                            s_wvalid,
  input  acc_pkg::lite_w_t                s_w,
  output logic                            s_wready,
  output logic                            s_bvalid,
  output logic [1:0]                      s_bresp,
  input  logic                            s_bready,
  input  logic                            s_arvalid,
  input  logic [acc_pkg::LITE_ADDR_W-1:0] s_araddr,
  output logic                            s_arready,
  output logic                            s_rvalid,
  output logic [acc_pkg::LITE_DATA_W-1:0] s_rdata,
  output logic [1:0]                      s_rresp,
  input  logic                            s_rready,
  output acc_pkg::axi_ar_t                ifm_ar,
  output logic                            ifm_arvalid,
  input  logic                            ifm_arready,
  input  acc_pkg::axi_r_t                 ifm_r,
  input  logic                            ifm_rvalid,
  output logic                            ifm_rready,
  output acc_pkg::axi_ar_t                wgt_ar,
  output logic                            wgt_arvalid,
  input  logic                            wgt_arready,
  input  acc_pkg::axi_r_t                 wgt_r,
  input  logic                            wgt_rvalid,
  output logic                            wgt_rready,
  output acc_pkg::axi_aw_t                ofm_aw,
  output logic                            ofm_awvalid,
  input  logic                            ofm_awready,
  output acc_pkg::axi_w_t                 ofm_w,
  output logic                            ofm_wvalid,
  input  logic                            ofm_wready,
  input  logic                            ofm_bvalid,
  output logic                            ofm_bready
);
  import acc_pkg::*;

  logic  ap_start;
  logic  ap_done;
  logic  ap_idle;
  addr_t ifm_base;
  addr_t wgt_base;
  addr_t ofm_base;
  logic  fetch_start;
  logic  ifm_done;
  logic  wgt_done;
  logic  write_start;
  logic  write_done;
  logic  ifm_valid;
  logic  wgt_valid;
  word_t ifm_word;
  word_t wgt_word;
  logic  pair_ready;
  logic  result_valid;
  word_t result;

  acc_ctrl_regs u_ctrl_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_awvalid (s_awvalid),
    .s_aw      (s_aw),
    .s_awready (s_awready),
    .s_wvalid  (s_wvalid),
    .s_w       (s_w),
    .s_wready  (s_wready),
    .s_bvalid  (s_bvalid),
    .s_bresp   (s_bresp),
    .s_bready  (s_bready),
    .s_arvalid (s_arvalid),
    .s_araddr  (s_araddr),
    .s_arready (s_arready),
    .s_rvalid  (s_rvalid),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rready  (s_rready),
    .ap_start  (ap_start),
    .ap_done   (ap_done),
    .ap_idle   (ap_idle),
    .ifm_base  (ifm_base),
    .wgt_base  (wgt_base),
    .ofm_base  (ofm_base)
  );

  acc_sequencer u_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .ap_start     (ap_start),
    .ifm_done     (ifm_done),
    .wgt_done     (wgt_done),
    .result_valid (result_valid),
    .write_done   (write_done),
    .fetch_start  (fetch_start),
    .write_start  (write_start),
    .ap_done      (ap_done),
    .ap_idle      (ap_idle)
  );

  axi_burst_reader u_ifm_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_start (fetch_start),
    .base        (ifm_base),
    .ar          (ifm_ar),
    .arvalid     (ifm_arvalid),
    .arready     (ifm_arready),
    .r           (ifm_r),
    .rvalid      (ifm_rvalid),
    .rready      (ifm_rready),
    .word_valid  (ifm_valid),
    .word        (ifm_word),
    .word_ready  (pair_ready),
    .fetch_done  (ifm_done)
  );

  axi_burst_reader u_wgt_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_start (fetch_start),
    .base        (wgt_base),
    .ar          (wgt_ar),
    .arvalid     (wgt_arvalid),
    .arready     (wgt_arready),
    .r           (wgt_r),
    .rvalid      (wgt_rvalid),
    .rready      (wgt_rready),
    .word_valid  (wgt_valid),
    .word        (wgt_word),
    .word_ready  (pair_ready),
    .fetch_done  (wgt_done)
  );

  mac_engine u_mac (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_start  (fetch_start),
    .ifm_valid    (ifm_valid),
    .ifm_word     (ifm_word),
    .wgt_valid    (wgt_valid),
    .wgt_word     (wgt_word),
    .pair_ready   (pair_ready),
    .result_valid (result_valid),
    .result       (result)
  );

  axi_word_writer u_ofm_writer (
    .clk         (clk),
    .rst_n       (rst_n),
    .write_start (write_start),
    .base        (ofm_base),
    .result      (result),
    .aw          (ofm_aw),
    .awvalid     (ofm_awvalid),
    .awready     (ofm_awready),
    .w           (ofm_w),
    .wvalid      (ofm_wvalid),
    .wready      (ofm_wready),
    .bvalid      (ofm_bvalid),
    .bready      (ofm_bready),
    .write_done  (write_done)
  );

endmodule

`default_nettype wire

/* sim/tb_krnl_acc.sv */
// accelerator kernel testbench
`default_nettype none
`timescale 1ns/1ps

module tb_krnl_acc;
  import acc_pkg::*;

  localparam int NUM_RUNS       = 6;
  localparam int TIMEOUT_CYCLES = 400 * NUM_RUNS;
  localparam int POLL_LIMIT     = 60;

  logic                   clk;
  logic                   rst_n;
  logic                   s_awvalid;
  lite_aw_t               s_aw;
  logic                   s_awready;
  logic                   s_wvalid;
  lite_w_t                s_w;
  logic                   s_wready;
  logic                   s_bvalid;
  logic [1:0]             s_bresp;
  logic                   s_bready;
  logic                   s_arvalid;
  logic [LITE_ADDR_W-1:0] s_araddr;
  logic                   s_arready;
  logic                   s_rvalid;
  logic [LITE_DATA_W-1:0] s_rdata;
  logic [1:0]             s_rresp;
  logic                   s_rready;
  axi_ar_t                ifm_ar;
  logic                   ifm_arvalid;
  logic                   ifm_arready;
  axi_r_t                 ifm_r;
  logic                   ifm_rvalid;
  logic                   ifm_rready;
  axi_ar_t                wgt_ar;
  logic                   wgt_arvalid;
  logic                   wgt_arready;
  axi_r_t                 wgt_r;
  logic                   wgt_rvalid;
  logic                   wgt_rready;
  axi_aw_t                ofm_aw;
  logic                   ofm_awvalid;
  logic                   ofm_awready;
  axi_w_t                 ofm_w;
  logic                   ofm_wvalid;
  logic                   ofm_wready;
  logic                   ofm_bvalid;
  logic                   ofm_bready;

  // memory contents and expectations of the current run
  word_t ifm_blk [BLOCK_WORDS];
  word_t wgt_blk [BLOCK_WORDS];
  addr_t exp_base [2];
  addr_t exp_ofm;
  int    ar_cnt [2] = '{0, 0};
  int    ofm_writes = 0;
  bit    stall_en = 1'b0;
  word_t exp_q [$];
  word_t got_q [$];
  int    err_cnt = 0;
  int    chk_cnt = 0;
  int    cycle_cnt;
  string test_name = "reset";

  krnl_acc i_krnl_acc (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_addr(input addr_t actual, input addr_t expected, input string what);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_len(input axlen_t actual, input axlen_t expected, input string what);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("CHECK FAILED [%s] %s: expected %0d, actual %0d", test_name, what, expected,
               actual);
    end
  endtask

  task automatic check_reg(input logic [LITE_DATA_W-1:0] actual,
                           input logic [LITE_DATA_W-1:0] expected, input string what);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  function automatic word_t byte_reverse(input word_t w);
    word_t res;
    res = '0;
    // first byte in ends up on top
    for (int b = 0; b < DATA_W / 8; b++) begin
      res = {res[DATA_W-9:0], w[b*8 +: 8]};
    end
    return res;
  endfunction

  function automatic word_t ref_result(input word_t ifm [BLOCK_WORDS],
                                       input word_t wgt [BLOCK_WORDS]);
    word_t a;
    word_t b;
    word_t res;
    lane_t sum [LANES];
    for (int l = 0; l < LANES; l++) begin
      sum[l] = '0;
    end
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      a = byte_reverse(ifm[i]);
      b = byte_reverse(wgt[i]);
      for (int l = 0; l < LANES; l++) begin
        sum[l] = sum[l] + a[l*LANE_W +: LANE_W] * b[l*LANE_W +: LANE_W];
      end
    end
    for (int l = 0; l < LANES; l++) begin
      res[l*LANE_W +: LANE_W] = {sum[l][7:0], sum[l][15:8], sum[l][23:16], sum[l][31:24]};
    end
    return res;
  endfunction

  function automatic logic draw_ready();
    if (!stall_en) begin
      return 1'b1;
    end
    return ($urandom % 2) == 1;
  endfunction

  task automatic write_reg(input logic [LITE_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    s_aw      = '{awaddr: addr};
    s_w       = '{wdata: data, wstrb: 4'hf};
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    s_bready  = 1'b1;
    @(posedge clk);
    while (!(s_awready && s_wready)) begin
      @(posedge clk);
    end
    @(negedge clk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    @(posedge clk);
    while (!s_bvalid) begin
      @(posedge clk);
    end
    check_reg(32'(s_bresp), 32'h0, "bresp");
  endtask

  task automatic read_reg(input logic [LITE_ADDR_W-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    s_rready  = 1'b1;
    @(posedge clk);
    while (!s_arready) begin
      @(posedge clk);
    end
    @(negedge clk);
    s_arvalid = 1'b0;
    @(posedge clk);
    while (!s_rvalid) begin
      @(posedge clk);
    end
    data = s_rdata;
    check_reg(32'(s_rresp), 32'h0, "rresp");
  endtask

  // memory model for both read channels and the ofm write channel
  initial begin : mem_model
    logic    ar_hs [2];
    logic    r_hs [2];
    axi_ar_t ar_s [2];
    logic    rd_active [2];
    int      rd_beat [2];
    logic    rv [2];
    logic    aw_hs;
    logic    w_hs;
    logic    b_hs;
    axi_aw_t aw_s;
    axi_w_t  w_s;
    logic    aw_done;
    logic    w_done;
    logic    bv;
    word_t   wr_data;
    string   ch_name;
    for (int ch = 0; ch < 2; ch++) begin
      rd_active[ch] = 1'b0;
      rd_beat[ch]   = 0;
      rv[ch]        = 1'b0;
    end
    aw_done     = 1'b0;
    w_done      = 1'b0;
    bv          = 1'b0;
    wr_data     = '0;
    ifm_arready = 1'b0;
    wgt_arready = 1'b0;
    ifm_rvalid  = 1'b0;
    wgt_rvalid  = 1'b0;
    ifm_r       = '0;
    wgt_r       = '0;
    ofm_awready = 1'b0;
    ofm_wready  = 1'b0;
    ofm_bvalid  = 1'b0;
    forever begin
      @(posedge clk);
      ar_hs[0] = ifm_arvalid && ifm_arready;
      ar_hs[1] = wgt_arvalid && wgt_arready;
      ar_s[0]  = ifm_ar;
      ar_s[1]  = wgt_ar;
      r_hs[0]  = ifm_rvalid && ifm_rready;
      r_hs[1]  = wgt_rvalid && wgt_rready;
      aw_hs    = ofm_awvalid && ofm_awready;
      w_hs     = ofm_wvalid && ofm_wready;
      b_hs     = ofm_bvalid && ofm_bready;
      aw_s     = ofm_aw;
      w_s      = ofm_w;
      @(negedge clk);
      for (int ch = 0; ch < 2; ch++) begin
        ch_name = (ch == 0) ? "ifm" : "wgt";
        if (ar_hs[ch]) begin
          ar_cnt[ch]++;
          check_addr(ar_s[ch].araddr, exp_base[ch], {ch_name, " araddr"});
          check_len(ar_s[ch].arlen, ARLEN_BLOCK, {ch_name, " arlen"});
          rd_active[ch] = 1'b1;
          rd_beat[ch]   = 0;
        end
        if (r_hs[ch]) begin
          rv[ch] = 1'b0;
          rd_beat[ch]++;
          if (rd_beat[ch] == BLOCK_WORDS) begin
            rd_active[ch] = 1'b0;
          end
        end
        // a raised rvalid stays up until its beat is taken
        if (rd_active[ch] && !rv[ch]) begin
          rv[ch] = draw_ready();
        end
      end
      ifm_arready = draw_ready();
      wgt_arready = draw_ready();
      ifm_rvalid  = rv[0];
      wgt_rvalid  = rv[1];
      ifm_r = '{rdata: rv[0] ? ifm_blk[rd_beat[0]] : word_t'(0),
                rlast: rv[0] && rd_beat[0] == BLOCK_WORDS - 1};
      wgt_r = '{rdata: rv[1] ? wgt_blk[rd_beat[1]] : word_t'(0),
                rlast: rv[1] && rd_beat[1] == BLOCK_WORDS - 1};

      if (b_hs) begin
        got_q.push_back(wr_data);
        ofm_writes++;
        bv      = 1'b0;
        aw_done = 1'b0;
        w_done  = 1'b0;
      end
      if (aw_hs) begin
        check_addr(aw_s.awaddr, exp_ofm, "ofm awaddr");
        check_len(aw_s.awlen, '0, "ofm awlen");
        aw_done = 1'b1;
      end
      if (w_hs) begin
        check_reg(32'({w_s.wlast, w_s.wstrb}), 32'h1_ffff, "ofm wlast and wstrb");
        wr_data = w_s.wdata;
        w_done  = 1'b1;
      end
      if (aw_done && w_done && !bv) begin
        bv = draw_ready();
      end
      ofm_awready = draw_ready();
      ofm_wready  = draw_ready();
      ofm_bvalid  = bv;
    end
  end

  // written words against the reference results, in run order
  always @(posedge clk) begin
    if (got_q.size() != 0) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("ERROR [%s]: ofm word written with no run pending", test_name);
        void'(got_q.pop_front());
      end else begin
        check_word(got_q.pop_front(), exp_q.pop_front(), "ofm data");
      end
    end
  end

  task automatic do_run(input bit restart_while_busy, input int run_idx);
    logic [31:0] rd;
    int          polls;
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      ifm_blk[i] = {$urandom, $urandom, $urandom, $urandom};
      wgt_blk[i] = {$urandom, $urandom, $urandom, $urandom};
    end
    exp_base[0] = addr_t'($urandom) & 32'hffff_fff0;
    exp_base[1] = addr_t'($urandom) & 32'hffff_fff0;
    exp_ofm     = addr_t'($urandom) & 32'hffff_fff0;
    write_reg(REG_IFM, exp_base[0]);
    write_reg(REG_WGT, exp_base[1]);
    write_reg(REG_OFM, exp_ofm);
    read_reg(REG_IFM, rd);
    check_addr(rd, exp_base[0], "ifm base readback");
    read_reg(REG_WGT, rd);
    check_addr(rd, exp_base[1], "wgt base readback");
    read_reg(REG_OFM, rd);
    check_addr(rd, exp_ofm, "ofm base readback");

    exp_q.push_back(ref_result(ifm_blk, wgt_blk));
    write_reg(REG_CTRL, 32'h1);
    if (restart_while_busy) begin
      read_reg(REG_CTRL, rd);
      check_reg(rd, 32'h0, "status while busy");
      // must not start a second run
      write_reg(REG_CTRL, 32'h1);
    end

    rd    = '0;
    polls = 0;
    while (!rd[1] && polls < POLL_LIMIT) begin
      read_reg(REG_CTRL, rd);
      polls++;
    end
    if (!rd[1]) begin
      err_cnt++;
      $display("ERROR [%s]: done bit not set after %0d status reads", test_name, polls);
    end else begin
      check_reg(rd, 32'h6, "status with done");
      read_reg(REG_CTRL, rd);
      check_reg(rd, 32'h4, "status after done read");
    end
    check_reg(32'(ofm_writes), 32'(run_idx + 1), "ofm write count");
    check_reg(32'(ar_cnt[0]), 32'(run_idx + 1), "ifm burst count");
    check_reg(32'(ar_cnt[1]), 32'(run_idx + 1), "wgt burst count");
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d, checks: %0d", err_cnt, chk_cnt);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    logic [31:0] rd;
    void'($urandom(13249));
    rst_n     = 1'b0;
    s_awvalid = 1'b0;
    s_aw      = '0;
    s_wvalid  = 1'b0;
    s_w       = '0;
    s_bready  = 1'b0;
    s_arvalid = 1'b0;
    s_araddr  = '0;
    s_rready  = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reg(32'({ifm_arvalid, wgt_arvalid, ofm_awvalid, ofm_wvalid, s_bvalid, s_rvalid}),
              32'h0, "valids after reset");
    read_reg(REG_CTRL, rd);
    check_reg(rd, 32'h4, "status after reset");

    test_name = "single run";
    do_run(1'b0, 0);
    stall_en = 1'b1;
    for (int i = 1; i < 3; i++) begin
      test_name = $sformatf("stalled run %0d", i);
      do_run(1'b0, i);
    end
    for (int i = 3; i < NUM_RUNS; i++) begin
      test_name = $sformatf("back-to-back run %0d", i);
      do_run(1'b1, i);
    end

    // nothing may move once the last run is over
    test_name = "final";
    repeat (20) @(negedge clk);
    check_reg(32'(ofm_writes), 32'(NUM_RUNS), "ofm write count");
    check_reg(32'(ar_cnt[0] + ar_cnt[1]), 32'(2 * NUM_RUNS), "burst count");
    check_reg(32'(exp_q.size()), 32'h0, "results not written");

    $display("errors: %0d, checks: %0d", err_cnt, chk_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hdl/acc_pkg.sv
hdl/acc_ctrl_regs.sv
hdl/axi_burst_reader.sv
hdl/axi_word_writer.sv
hdl/acc_sequencer.sv
hdl/mac_engine.sv
hdl/krnl_acc.sv
sim/tb_krnl_acc.sv

/* Bender.yml */
package:
  name: krnl_acc

sources:
  - files:
      - hdl/acc_pkg.sv
      - hdl/acc_ctrl_regs.sv
      - hdl/axi_burst_reader.sv
      - hdl/axi_word_writer.sv
      - hdl/acc_sequencer.sv
      - hdl/mac_engine.sv
      - hdl/krnl_acc.sv
  - target: simulation
    files:
      - sim/tb_krnl_acc.sv
